/* Bender.yml */
package:
  name: vdma_write

sources:
  - vdma_pkg.sv
  - pixel_packer.sv
  - stream_fifo.sv
  - burst_scheduler.sv
  - axi_write_engine.sv
  - vdma_write_top.sv
  - target: test
    files:
      - tb_vdma_write.sv

/* axi_write_engine.sv */
// AXI write engine
// runs one INCR write burst per request through AW, W and B
// pops the beat FIFO on every accepted W beat
module axi_write_engine import vdma_pkg::*; #(
    parameter int AXI_ID = 0
) (
    input  logic       clock,
    input  logic       arst_n,
    input  logic       burst_req,
    input  addr_t      req_addr,
    input  burst_len_t req_len,
    output logic       req_done,
    input  logic       fifo_empty,
    input  beat_t      fifo_dout,
    output logic       fifo_pop,
    output axi_id_t    awid,
    output addr_t      awaddr,
    output burst_len_t awlen,
    output logic [2:0] awsize,
    output logic [1:0] awburst,
    output logic       awvalid,
    input  logic       awready,
    output beat_t      wdata,
    output logic       wlast,
    output logic       wvalid,
    input  logic       wready,
    input  axi_id_t    bid,
    input  logic [1:0] bresp,
    input  logic       bvalid,
    output logic       bready
);

    wr_state_t  state;
    burst_len_t beat_cnt;
    logic       w_fire;

    // fixed burst attributes
    assign awid    = axi_id_t'(AXI_ID);
    assign awsize  = AXI_SIZE;
    assign awburst = AXI_BURST_INCR;

    // data straight from the fifo head
    assign wdata    = fifo_dout;
    assign wvalid   = (state == WR_DATA) && !fifo_empty;
    assign wlast    = (state == WR_DATA) && (beat_cnt == awlen);
    assign w_fire   = wvalid && wready;
    assign fifo_pop = w_fire;

    // address and length latched when leaving idle
    always_ff @(posedge clock) begin
        if (state == WR_IDLE && burst_req && !req_done) begin
            awaddr <= req_addr;
            awlen  <= req_len;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state    <= WR_IDLE;
            awvalid  <= 1'b0;
            bready   <= 1'b0;
            req_done <= 1'b0;
            beat_cnt <= '0;
        end else begin
            req_done <= 1'b0;
            case (state)
                WR_IDLE: begin
                    // request still high during the done pulse, skip it
                    if (burst_req && !req_done) begin
                        state    <= WR_ADDR;
                        awvalid  <= 1'b1;
                        beat_cnt <= '0;
                    end
                end
                WR_ADDR: begin
                    if (awready) begin
                        awvalid <= 1'b0;
                        state   <= WR_DATA;
                    end
                end
                WR_DATA: begin
                    if (w_fire) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (wlast) begin
                            bready <= 1'b1;
                            state  <= WR_RESP;
                        end
                    end
                end
                WR_RESP: begin
                    // response code not inspected
                    if (bvalid) begin
                        bready   <= 1'b0;
                        req_done <= 1'b1;
                        state    <= WR_IDLE;
                    end
                end
                default: begin
                    state <= WR_IDLE;
                end
            endcase
        end
    end

endmodule

/* burst_scheduler.sv */
// burst scheduler
// tracks beats not yet requested and issues full or tail burst requests
// keeps the frame write address, reloaded from baseaddr at frame close
module burst_scheduler import vdma_pkg::*; #(
    parameter int BURST_LEN = 16
) (
    input  logic       clock,
    input  logic       arst_n,
    input  logic       beat_push,
    input  logic       frame_end,
    input  addr_t      baseaddr,
    input  logic       req_done,
    output logic       burst_req,
    output addr_t      req_addr,
    output burst_len_t req_len
);

    sched_state_t state;
    count_t       pending;
    logic         tail_pend;
    logic         issue;
    count_t       issue_beats;
    addr_t        addr;
    addr_t        addr_step;

    assign req_addr = addr;

    // issue states last one cycle, that is when pending gets charged
    assign issue       = (state == SCHED_REQ_FULL) || (state == SCHED_REQ_TAIL);
    assign issue_beats = issue ? count_t'(req_len) + count_t'(1) : '0;

    // bytes covered by the request just completed
    assign addr_step = (addr_t'(req_len) + addr_t'(1)) << $clog2(BEAT_BYTES);

    // beats packed but not yet handed to a request
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            pending <= '0;
        end else begin
            pending <= pending + count_t'(beat_push) - issue_beats;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state     <= SCHED_IDLE;
            burst_req <= 1'b0;
            req_len   <= '0;
            addr      <= '0;
            // set so the first idle cycle loads the base address
            tail_pend <= 1'b1;
        end else begin
            case (state)
                SCHED_IDLE: begin
                    if (pending >= count_t'(BURST_LEN)) begin
                        state     <= SCHED_REQ_FULL;
                        burst_req <= 1'b1;
                        req_len   <= burst_len_t'(BURST_LEN - 1);
                    end else if (tail_pend) begin
                        if (pending != '0) begin
                            // short burst drains the remainder
                            state     <= SCHED_REQ_TAIL;
                            burst_req <= 1'b1;
                            req_len   <= burst_len_t'(pending - count_t'(1));
                        end else begin
                            // frame closed, next frame starts at base
                            addr      <= baseaddr;
                            tail_pend <= 1'b0;
                        end
                    end
                end
                SCHED_REQ_FULL, SCHED_REQ_TAIL: begin
                    state <= SCHED_WAIT_DONE;
                end
                SCHED_WAIT_DONE: begin
                    // engine done with the burst
                    if (req_done) begin
                        burst_req <= 1'b0;
                        addr      <= addr + addr_step;
                        state     <= SCHED_IDLE;
                    end
                end
                default: begin
                    state     <= SCHED_IDLE;
                    burst_req <= 1'b0;
                end
            endcase
            // a new frame end always wins over the clear above
            if (frame_end) begin
                tail_pend <= 1'b1;
            end
        end
    end

endmodule

/* compile.f */
vdma_pkg.sv
pixel_packer.sv
stream_fifo.sv
burst_scheduler.sv
axi_write_engine.sv
vdma_write_top.sv
tb_vdma_write.sv

/* pixel_packer.sv */
// pixel packer
// packs five 24-bit pixels top-down into one 128-bit beat
// flushes a zero-padded partial beat when vsync rises, then flags frame end
module pixel_packer import vdma_pkg::*; (
    input  logic  clock,
    input  logic  arst_n,
    input  logic  vsync,
    input  logic  de,
    input  pix_t  idata,
    output logic  beat_push,
    output beat_t beat,
    output logic  frame_end
);

    localparam logic [2:0] LAST_SLOT = 3'(PIX_PER_BEAT - 1);

    logic       vsync_d;
    logic       vsync_rise;
    logic       pix_vld;
    logic       flush_d;
    logic [2:0] slot;
    beat_t      acc;
    beat_t      filled;

    assign vsync_rise = vsync && !vsync_d;
    // no pixels during vertical blanking
    assign pix_vld = de && !vsync;

    // accumulator with the incoming pixel dropped into its slot
    always_comb begin
        filled = acc;
        filled[BEAT_W-1 - int'(slot)*PIX_W -: PIX_W] = idata;
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            vsync_d   <= 1'b0;
            flush_d   <= 1'b0;
            frame_end <= 1'b0;
            beat_push <= 1'b0;
            slot      <= '0;
            acc       <= '0;
        end else begin
            vsync_d   <= vsync;
            beat_push <= 1'b0;
            // frame_end trails the flush beat by one cycle
            flush_d   <= vsync_rise;
            frame_end <= flush_d;
            if (vsync_rise) begin
                // partial beat only if some slot holds a pixel
                beat_push <= (slot != '0);
                slot      <= '0;
                acc       <= '0;
            end else if (pix_vld) begin
                if (slot == LAST_SLOT) begin
                    beat_push <= 1'b1;
                    slot      <= '0;
                    acc       <= '0;
                end else begin
                    acc  <= filled;
                    slot <= slot + 3'd1;
                end
            end
        end
    end

    // output beat register
    always_ff @(posedge clock) begin
        if (vsync_rise) begin
            // unfilled slots are still zero
            beat <= acc;
        end else if (pix_vld && slot == LAST_SLOT) begin
            beat <= filled;
        end
    end

endmodule

/* stream_fifo.sv */
// stream FIFO for packed beats
// single clock, show-ahead read, registered almost-full flag
module stream_fifo import vdma_pkg::*; #(
    parameter int FIFO_DEPTH = 64
) (
    input  logic   clock,
    input  logic   arst_n,
    input  logic   push,
    input  beat_t  din,
    input  logic   pop,
    output beat_t  dout,
    output logic   empty,
    output logic   almost_full,
    output count_t count
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    beat_t            mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             full;
    logic             do_push;
    logic             do_pop;

    assign full  = (count == count_t'(FIFO_DEPTH));
    assign empty = (count == '0);

    // writes to a full fifo are lost
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // head entry shown ahead
    assign dout = mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            almost_full <= 1'b0;
        end else begin
            // pointers wrap naturally, depth is a power of two
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + count_t'(1);
                2'b01:   count <= count - count_t'(1);
                default: count <= count;
            endcase
            // flag lags the occupancy by a cycle
            almost_full <= (count >= count_t'(FIFO_DEPTH - ALMOST_MARGIN));
        end
    end

endmodule

/* tb_vdma_write.sv */
// testbench for the video frame writer
// drives raster frames, acts as an AXI write slave with random stalls
// and checks every AW and W handshake against a reference model
module tb_vdma_write import vdma_pkg::*; ();

    localparam int BURST_LEN    = 8;
    localparam int FIFO_DEPTH   = 32;
    localparam int AXI_ID       = 5;
    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_FRAMES   = 5;
    localparam int BLANK_CYCLES = 200;
    // longest frame plus its blanking
    localparam int FRAME_LEN    = 400 + BLANK_CYCLES;
    localparam int WATCH_CYCLES = NUM_FRAMES * FRAME_LEN * 20;
    // frame run with long wready stalls
    localparam int BP_FRAME     = 2;

    logic       clock;
    logic       arst_n;
    logic       vsync;
    logic       de;
    pix_t       idata;
    addr_t      baseaddr;
    logic       fifo_almost_full;
    axi_id_t    awid;
    addr_t      awaddr;
    burst_len_t awlen;
    logic [2:0] awsize;
    logic [1:0] awburst;
    logic       awvalid;
    logic       awready;
    beat_t      wdata;
    logic       wlast;
    logic       wvalid;
    logic       wready;
    axi_id_t    bid;
    logic [1:0] bresp;
    logic       bvalid;
    logic       bready;

    // 400 full bursts, 93 tail + partial, 300 back-pressure, 40 exact, 15 tail only
    int    frame_pix [NUM_FRAMES] = '{400, 93, 300, 40, 15};
    addr_t frame_base [NUM_FRAMES] = '{32'h1000_0000, 32'h2000_0000, 32'h3000_0400,
                                       32'h4000_0000, 32'h5000_0000};
    int    burst_total [NUM_FRAMES];

    integer     seed;
    pix_t       all_pix [$];
    addr_t      exp_addr_q [$];
    burst_len_t exp_len_q [$];
    beat_t      exp_beat_q [$];
    logic       exp_last_q [$];
    int         pix_idx;
    int         bursts_done;
    int         bp_cnt;
    logic       bp_mode;
    logic       af_seen;
    int         err_addr;
    int         err_len;
    int         err_beat;
    int         err_flag;
    int         err_attr;
    int         err_other;
    int         first_pix;
    int         err_total;

    vdma_write_top #(
        .BURST_LEN  (BURST_LEN),
        .FIFO_DEPTH (FIFO_DEPTH),
        .AXI_ID     (AXI_ID)
    ) DUT (.*);

    always #(CLK_PERIOD / 2) clock = ~clock;

    // expected beat with pixel 0 on top and zeros below the last pixel
    function automatic beat_t ref_beat(int first, int npix);
        beat_t r;
        r = '0;
        for (int i = 0; i < PIX_PER_BEAT; i++) begin
            r = r << PIX_W;
            if (i < npix) begin
                r[PIX_W-1:0] = all_pix[first + i];
            end
        end
        return r << (BEAT_W - PIX_PER_BEAT * PIX_W);
    endfunction

    // awlen of burst k in a frame of nbeats beats
    function automatic burst_len_t ref_burst_len(int nbeats, int k);
        if ((k + 1) * BURST_LEN <= nbeats) begin
            return burst_len_t'(BURST_LEN - 1);
        end
        return burst_len_t'(nbeats - k * BURST_LEN - 1);
    endfunction

    task automatic expect_frame(int f, int first);
        int nbeats;
        int nbursts;
        int left;
        nbeats  = (frame_pix[f] + PIX_PER_BEAT - 1) / PIX_PER_BEAT;
        nbursts = (nbeats + BURST_LEN - 1) / BURST_LEN;
        for (int k = 0; k < nbursts; k++) begin
            exp_addr_q.push_back(frame_base[f] + addr_t'(k * BURST_LEN * BEAT_BYTES));
            exp_len_q.push_back(ref_burst_len(nbeats, k));
        end
        for (int b = 0; b < nbeats; b++) begin
            left = frame_pix[f] - b * PIX_PER_BEAT;
            exp_beat_q.push_back(ref_beat(first + b * PIX_PER_BEAT,
                                          (left < PIX_PER_BEAT) ? left : PIX_PER_BEAT));
            exp_last_q.push_back((b % BURST_LEN == BURST_LEN - 1) || (b == nbeats - 1));
        end
        burst_total[f] = ((f == 0) ? 0 : burst_total[f-1]) + nbursts;
    endtask

    task automatic check_addr(addr_t act, addr_t exp, string what);
        if (act !== exp) begin
            err_addr++;
            $display("ERR %0t: %s is %h, expected %h", $time, what, act, exp);
        end
    endtask

    task automatic check_len(burst_len_t act, burst_len_t exp, string what);
        if (act !== exp) begin
            err_len++;
            $display("ERR %0t: %s is %0d, expected %0d", $time, what, act, exp);
        end
    endtask

    task automatic check_beat(beat_t act, beat_t exp, string what);
        if (act !== exp) begin
            err_beat++;
            $display("ERR %0t: %s is %h, expected %h", $time, what, act, exp);
        end
    endtask

    task automatic check_flag(logic act, logic exp, string what);
        if (act !== exp) begin
            err_flag++;
            $display("ERR %0t: %s is %b, expected %b", $time, what, act, exp);
        end
    endtask

    task automatic check_id(axi_id_t act, axi_id_t exp, string what);
        if (act !== exp) begin
            err_attr++;
            $display("ERR %0t: %s is %0d, expected %0d", $time, what, act, exp);
        end
    endtask

    task automatic check_size(logic [2:0] act, logic [2:0] exp, string what);
        if (act !== exp) begin
            err_attr++;
            $display("ERR %0t: %s is %0d, expected %0d", $time, what, act, exp);
        end
    endtask

    task automatic check_burst(logic [1:0] act, logic [1:0] exp, string what);
        if (act !== exp) begin
            err_attr++;
            $display("ERR %0t: %s is %b, expected %b", $time, what, act, exp);
        end
    endtask

    task automatic check_idle_outputs();
        check_flag(awvalid, 1'b0, "awvalid after reset");
        check_flag(wvalid, 1'b0, "wvalid after reset");
        check_flag(bready, 1'b0, "bready after reset");
        check_flag(fifo_almost_full, 1'b0, "fifo_almost_full after reset");
    endtask

    // one active frame, then blanking until the frame has drained
    task automatic run_frame(int f);
        int sent;
        int cnt;
        @(posedge clock);
        vsync   <= 1'b0;
        bp_mode <= (f == BP_FRAME);
        af_seen = 1'b0;
        sent = 0;
        while (sent < frame_pix[f]) begin
            @(posedge clock);
            // random gaps, and no pixels while the fifo is nearly full
            if (!fifo_almost_full && ($random(seed) & 3) != 0) begin
                de    <= 1'b1;
                idata <= all_pix[pix_idx];
                pix_idx++;
                sent++;
            end else begin
                de <= 1'b0;
            end
        end
        @(posedge clock);
        de    <= 1'b0;
        vsync <= 1'b1;
        // picked up by the address reload after this frame closes
        if (f + 1 < NUM_FRAMES) begin
            baseaddr <= frame_base[f+1];
        end
        cnt = 0;
        while (cnt < BLANK_CYCLES || bursts_done != burst_total[f]) begin
            @(posedge clock);
            cnt++;
        end
        repeat (4) @(posedge clock);
        if (f == BP_FRAME) begin
            bp_mode <= 1'b0;
            if (!af_seen) begin
                err_other++;
                $display("fifo_almost_full never rose while wready was stalled");
            end
        end
    endtask

    // AXI slave with random stalls and long wready gaps in the back-pressure frame
    always @(posedge clock) begin
        // stall phase restarts with the back-pressure frame
        bp_cnt  <= bp_mode ? bp_cnt + 1 : 0;
        awready <= ($random(seed) & 3) != 0;
        if (bp_mode) begin
            // 250 stalled cycles, then 50 open ones
            wready <= (bp_cnt % 300) >= 250;
        end else begin
            wready <= ($random(seed) & 3) != 0;
        end
        if (bvalid && bready) begin
            bvalid      <= 1'b0;
            bursts_done <= bursts_done + 1;
        end else if (wvalid && wready && wlast) begin
            bvalid <= 1'b1;
        end
    end

    // compare on the falling edge where handshake signals are settled
    always @(negedge clock) begin
        if (arst_n) begin
            if (fifo_almost_full) begin
                af_seen = 1'b1;
            end
            if (awvalid && awready) begin
                if (exp_addr_q.size() == 0) begin
                    err_other++;
                    $display("unexpected AW burst at time %0t", $time);
                end else begin
                    check_addr(awaddr, exp_addr_q.pop_front(), "awaddr");
                    check_len(awlen, exp_len_q.pop_front(), "awlen");
                    check_id(awid, axi_id_t'(AXI_ID), "awid");
                    // 16-byte beats in an INCR burst
                    check_size(awsize, 3'd4, "awsize");
                    check_burst(awburst, 2'b01, "awburst");
                end
            end
            if (wvalid && wready) begin
                if (exp_beat_q.size() == 0) begin
                    err_other++;
                    $display("unexpected W beat at time %0t", $time);
                end else begin
                    check_beat(wdata, exp_beat_q.pop_front(), "wdata");
                    check_flag(wlast, exp_last_q.pop_front(), "wlast");
                end
            end
        end
    end

    initial begin
        #(WATCH_CYCLES * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d cycles", WATCH_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        seed        = 32'h17f6e4ce;
        clock       = 1'b0;
        arst_n      = 1'b0;
        vsync       = 1'b1;
        de          = 1'b0;
        idata       = '0;
        baseaddr    = frame_base[0];
        awready     = 1'b0;
        wready      = 1'b0;
        bid         = '0;
        bresp       = '0;
        bvalid      = 1'b0;
        bp_mode     = 1'b0;
        bp_cnt      = 0;
        af_seen     = 1'b0;
        bursts_done = 0;
        pix_idx     = 0;
        err_addr    = 0;
        err_len     = 0;
        err_beat    = 0;
        err_flag    = 0;
        err_attr    = 0;
        err_other   = 0;
        // pixels and expected traffic for all frames
        first_pix = 0;
        for (int f = 0; f < NUM_FRAMES; f++) begin
            for (int i = 0; i < frame_pix[f]; i++) begin
                all_pix.push_back(pix_t'($random(seed)));
            end
            expect_frame(f, first_pix);
            first_pix += frame_pix[f];
        end
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(negedge clock);
            check_idle_outputs();
        end
        @(posedge clock);
        arst_n <= 1'b1;
        @(negedge clock);
        check_idle_outputs();
        for (int f = 0; f < NUM_FRAMES; f++) begin
            run_frame(f);
        end
        repeat (10) @(posedge clock);
        if (exp_beat_q.size() != 0 || exp_addr_q.size() != 0) begin
            err_other++;
            $display("%0d beats and %0d bursts never arrived",
                     exp_beat_q.size(), exp_addr_q.size());
        end
        err_total = err_addr + err_len + err_beat + err_flag + err_attr + err_other;
        $display("errors: addr %0d, len %0d, beat %0d, flag %0d, attr %0d, other %0d",
                 err_addr, err_len, err_beat, err_flag, err_attr, err_other);
        if (err_total == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* vdma_pkg.sv */
// video frame writer shared definitions
// pixel and beat geometry, AXI constants, common types and FSM states
package vdma_pkg;

    // pixel and beat geometry
    localparam int PIX_W        = 24;
    localparam int PIX_PER_BEAT = 5;
    localparam int BEAT_W       = 128;
    localparam int BEAT_BYTES   = 16;
    localparam int ID_W         = 4;

    // AXI encodings, 16 bytes per beat
    localparam logic [2:0] AXI_SIZE       = 3'd4;
    localparam logic [1:0] AXI_BURST_INCR = 2'b01;

    // free entries left when the source gets told to stop
    localparam int ALMOST_MARGIN = 4;

    typedef logic [PIX_W-1:0]  pix_t;
    typedef logic [BEAT_W-1:0] beat_t;
    typedef logic [31:0]       addr_t;
    typedef logic [7:0]        burst_len_t;
    // fifo occupancy and pending beats, depth up to 512
    typedef logic [9:0]        count_t;
    typedef logic [ID_W-1:0]   axi_id_t;

    typedef enum logic [1:0] {
        SCHED_IDLE,
        SCHED_REQ_FULL,
        SCHED_REQ_TAIL,
        SCHED_WAIT_DONE
    } sched_state_t;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_ADDR,
        WR_DATA,
        WR_RESP
    } wr_state_t;

endpackage

/* vdma_write_top.sv */
// video frame writer top level
// raster pixels in, packed beats out as AXI4 write bursts
module vdma_write_top import vdma_pkg::*; #(
    parameter int BURST_LEN  = 16,
    parameter int FIFO_DEPTH = 64,
    parameter int AXI_ID     = 0
) (
    input  logic       clock,
    input  logic       arst_n,
    input  logic       vsync,
    input  logic       de,
    input  pix_t       idata,
    input  addr_t      baseaddr,
    output logic       fifo_almost_full,
    output axi_id_t    awid,
    output addr_t      awaddr,
    output burst_len_t awlen,
    output logic [2:0] awsize,
    output logic [1:0] awburst,
    output logic       awvalid,
    input  logic       awready,
    output beat_t      wdata,
    output logic       wlast,
    output logic       wvalid,
    input  logic       wready,
    input  axi_id_t    bid,
    input  logic [1:0] bresp,
    input  logic       bvalid,
    output logic       bready
);

    // packer to fifo and scheduler
    logic       beat_push;
    beat_t      beat;
    logic       frame_end;
    // fifo and engine
    logic       fifo_empty;
    beat_t      fifo_dout;
    logic       fifo_pop;
    // scheduler and engine request handshake
    logic       burst_req;
    addr_t      req_addr;
    burst_len_t req_len;
    logic       req_done;

    pixel_packer u_packer (
        .clock     (clock),
        .arst_n    (arst_n),
        .vsync     (vsync),
        .de        (de),
        .idata     (idata),
        .beat_push (beat_push),
        .beat      (beat),
        .frame_end (frame_end)
    );

    stream_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clock       (clock),
        .arst_n      (arst_n),
        .push        (beat_push),
        .din         (beat),
        .pop         (fifo_pop),
        .dout        (fifo_dout),
        .empty       (fifo_empty),
        .almost_full (fifo_almost_full),
        .count       ()
    );

    burst_scheduler #(
        .BURST_LEN (BURST_LEN)
    ) u_sched (
        .clock     (clock),
        .arst_n    (arst_n),
        .beat_push (beat_push),
        .frame_end (frame_end),
        .baseaddr  (baseaddr),
        .req_done  (req_done),
        .burst_req (burst_req),
        .req_addr  (req_addr),
        .req_len   (req_len)
    );

    axi_write_engine #(
        .AXI_ID (AXI_ID)
    ) u_engine (
        .clock      (clock),
        .arst_n     (arst_n),
        .burst_req  (burst_req),
        .req_addr   (req_addr),
        .req_len    (req_len),
        .req_done   (req_done),
        .fifo_empty (fifo_empty),
        .fifo_dout  (fifo_dout),
        .fifo_pop   (fifo_pop),
        .awid       (awid),
        .awaddr     (awaddr),
        .awlen      (awlen),
        .awsize     (awsize),
        .awburst    (awburst),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wlast      (wlast),
        .wvalid     (wvalid),
        .wready     (wready),
        .bid        (bid),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready)
    );

endmodule
